// File: common/sv32_pkg.sv
package sv32_pkg;

  // ------------------------------------------------------------------------
  // address geometry
  // ------------------------------------------------------------------------

  localparam int VADDR_W    = 32;
  localparam int PADDR_W    = 34;
  localparam int PG_IDX_W   = 12;
  localparam int VPN_W      = 20;
  localparam int VPN_PART_W = 10;
  localparam int PPN_W      = 22;

  // mode bit of satp, the root ppn sits in the low PPN_W bits
  localparam int SATP_MODE_BIT = 31;

  // ------------------------------------------------------------------------
  // page-table entry
  // ------------------------------------------------------------------------

  // full entry width
  localparam int PTE_WIDTH   = 32;
  // ppn field starts above the flags and the two rsw bits
  localparam int PTE_PPN_LSB = 10;

  localparam int PTE_V = 0;
  localparam int PTE_R = 1;
  localparam int PTE_W = 2;
  localparam int PTE_X = 3;
  localparam int PTE_U = 4;
  localparam int PTE_G = 5;
  localparam int PTE_A = 6;
  localparam int PTE_D = 7;

  // privilege levels as encoded in mstatus.mpp
  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_S = 2'b01,
    PRV_M = 2'b11
  } priv_t;

endpackage

// File: common/mmu_pkg.sv
package mmu_pkg;

  // ------------------------------------------------------------------------
  // TLB organisation
  // ------------------------------------------------------------------------

  localparam int TLB_ENTRIES = 8;
  localparam int TLB_IDX_W   = 3;

  // access kind coming from the load/store unit or the fetch path
  typedef enum logic [1:0] {
    CMD_LOAD  = 2'd0,
    CMD_STORE = 2'd1,
    CMD_FETCH = 2'd2
  } acc_cmd_t;

  // ------------------------------------------------------------------------
  // state machines
  // ------------------------------------------------------------------------

  // miss handling in the TLB
  typedef enum logic [1:0] {
    ST_READY           = 2'd0,
    ST_REQUEST         = 2'd1,
    ST_WAIT            = 2'd2,
    ST_WAIT_INVALIDATE = 2'd3
  } tlb_state_t;

  // two-level walk
  typedef enum logic [1:0] {
    PTW_IDLE = 2'd0,
    PTW_L1   = 2'd1,
    PTW_L0   = 2'd2,
    PTW_DONE = 2'd3
  } ptw_state_t;

endpackage

// File: tlb/tlb_entry_array.sv
`timescale 1ns/1ps

module tlb_entry_array
  import sv32_pkg::*, mmu_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  input  logic [VPN_W-1:0]     i_lookup_vpn,
  output logic                 o_hit,
  output logic [PTE_WIDTH-1:0] o_hit_pte,
  output logic                 o_hit_mega,

  input  logic                 i_fill_valid,
  input  logic [VPN_W-1:0]     i_fill_vpn,
  input  logic [PTE_WIDTH-1:0] i_fill_pte,
  input  logic                 i_fill_mega,
  input  logic                 i_flush
);

  logic [TLB_ENTRIES-1:0] r_valid;
  logic [TLB_IDX_W-1:0]   r_victim;
  logic [VPN_W-1:0]       r_tag [TLB_ENTRIES];
  logic                   r_mega [TLB_ENTRIES];
  logic [PTE_WIDTH-1:0]   r_pte [TLB_ENTRIES];

  logic [TLB_ENTRIES-1:0] w_match;
  logic                   w_write;

  // a flush wins over a fill in the same cycle
  assign w_write = i_fill_valid & ~i_flush;

  // ------------------------------------------------------------------------
  // tag compare
  // ------------------------------------------------------------------------

  // megapages ignore VPN[0]
  for (genvar e = 0; e < TLB_ENTRIES; e++) begin : g_match
    assign w_match[e] = r_valid[e]
                      & (r_tag[e][VPN_W-1 -: VPN_PART_W] == i_lookup_vpn[VPN_W-1 -: VPN_PART_W])
                      & (r_mega[e] | (r_tag[e][VPN_PART_W-1:0] == i_lookup_vpn[VPN_PART_W-1:0]));
  end

  // at most one entry matches, so the fields are simply OR-ed together
  always_comb begin
    o_hit      = 1'b0;
    o_hit_pte  = '0;
    o_hit_mega = 1'b0;
    for (int e = 0; e < TLB_ENTRIES; e++) begin
      o_hit      = o_hit | w_match[e];
      o_hit_pte  = o_hit_pte | ({PTE_WIDTH{w_match[e]}} & r_pte[e]);
      o_hit_mega = o_hit_mega | (w_match[e] & r_mega[e]);
    end
  end

  // ------------------------------------------------------------------------
  // valid bits and round-robin victim
  // ------------------------------------------------------------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= '0;
      r_victim <= '0;
    end else if (i_flush) begin
      r_valid <= '0;
    end else if (i_fill_valid) begin
      r_valid[r_victim] <= 1'b1;
      r_victim          <= r_victim + 1'b1;
    end
  end

  // entry payload
  always_ff @(posedge i_clk) begin
    if (w_write) begin
      r_tag[r_victim]  <= i_fill_vpn;
      r_mega[r_victim] <= i_fill_mega;
      r_pte[r_victim]  <= i_fill_pte;
    end
  end

endmodule

// File: tlb/tlb.sv
`timescale 1ns/1ps

module tlb
  import sv32_pkg::*, mmu_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  input  logic                 i_req_valid,
  input  logic [VADDR_W-1:0]   i_req_vaddr,
  input  acc_cmd_t             i_req_cmd,
  input  logic [1:0]           i_req_size,
  output logic                 o_req_ready,
  output logic                 o_resp_miss,
  output logic [PADDR_W-1:0]   o_resp_paddr,
  output logic                 o_resp_pf,
  output logic                 o_resp_ma,

  input  logic                 i_sfence_valid,
  input  logic                 i_kill,
  input  priv_t                i_priv,
  input  logic                 i_satp_mode,
  input  logic                 i_mstatus_sum,
  input  logic                 i_mstatus_mxr,

  output logic                 o_ptw_req_valid,
  output logic [VPN_W-1:0]     o_ptw_req_vpn,
  input  logic                 i_ptw_req_ready,
  input  logic                 i_ptw_resp_valid,
  input  logic [PTE_WIDTH-1:0] i_ptw_resp_pte,
  input  logic                 i_ptw_resp_mega
);

  tlb_state_t r_state;
  logic [VPN_W-1:0]     r_refill_vpn;

  logic [VPN_W-1:0]     w_vpn;
  logic                 w_vm_on;
  logic                 w_hit;
  logic [PTE_WIDTH-1:0] w_hit_pte;
  logic                 w_hit_mega;
  logic [PPN_W-1:0]     w_ppn;
  logic                 w_perm_fault;
  logic [1:0]           w_align_mask;

  assign w_vpn   = i_req_vaddr[VADDR_W-1:PG_IDX_W];
  // machine mode always runs untranslated
  assign w_vm_on = i_satp_mode & (i_priv != PRV_M);

  tlb_entry_array tlb_entry_array_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_lookup_vpn (w_vpn),
    .o_hit        (w_hit),
    .o_hit_pte    (w_hit_pte),
    .o_hit_mega   (w_hit_mega),
    .i_fill_valid (i_ptw_resp_valid & (r_state == ST_WAIT)),
    .i_fill_vpn   (r_refill_vpn),
    .i_fill_pte   (i_ptw_resp_pte),
    .i_fill_mega  (i_ptw_resp_mega),
    .i_flush      (i_sfence_valid)
  );

  // ------------------------------------------------------------------------
  // response
  // ------------------------------------------------------------------------

  assign w_ppn = w_hit_pte[PTE_WIDTH-1:PTE_PPN_LSB];

  always_comb begin
    if (!w_vm_on) begin
      o_resp_paddr = {{(PADDR_W-VADDR_W){1'b0}}, i_req_vaddr};
    end else if (w_hit_mega) begin
      // VPN[0] passes straight through for a megapage
      o_resp_paddr = {w_ppn[PPN_W-1:VPN_PART_W], i_req_vaddr[VADDR_W-VPN_PART_W-1:0]};
    end else begin
      o_resp_paddr = {w_ppn, i_req_vaddr[PG_IDX_W-1:0]};
    end
  end

  // permission, A/D and privilege checks on the hit entry
  assign w_perm_fault =
      ~w_hit_pte[PTE_V] | ~w_hit_pte[PTE_A]
    | ((i_req_cmd == CMD_STORE) & (~w_hit_pte[PTE_W] | ~w_hit_pte[PTE_D]))
    | ((i_req_cmd == CMD_LOAD) & ~(w_hit_pte[PTE_R] | (w_hit_pte[PTE_X] & i_mstatus_mxr)))
    | ((i_req_cmd == CMD_FETCH) & ~w_hit_pte[PTE_X])
    | ((i_priv == PRV_U) & ~w_hit_pte[PTE_U])
    | ((i_priv == PRV_S) & w_hit_pte[PTE_U] & ((i_req_cmd == CMD_FETCH) | ~i_mstatus_sum));

  assign o_resp_pf   = w_vm_on & w_hit & w_perm_fault;
  assign o_resp_miss = w_vm_on & ~w_hit;

  always_comb begin
    case (i_req_size)
      2'd0:    w_align_mask = 2'b00;
      2'd1:    w_align_mask = 2'b01;
      default: w_align_mask = 2'b11;
    endcase
  end

  assign o_resp_ma = |(i_req_vaddr[1:0] & w_align_mask);

  // ------------------------------------------------------------------------
  // miss handling
  // ------------------------------------------------------------------------

  assign o_req_ready     = (r_state == ST_READY);
  assign o_ptw_req_valid = (r_state == ST_REQUEST) & ~i_kill;
  assign o_ptw_req_vpn   = r_refill_vpn;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_READY;
    end else begin
      case (r_state)
        ST_READY: begin
          if (i_req_valid & o_resp_miss) begin
            r_state <= ST_REQUEST;
          end
        end
        ST_REQUEST: begin
          if (i_kill) begin
            r_state <= ST_READY;
          end else if (i_ptw_req_ready) begin
            r_state <= i_sfence_valid ? ST_WAIT_INVALIDATE : ST_WAIT;
          end else if (i_sfence_valid) begin
            r_state <= ST_READY;
          end
        end
        ST_WAIT: begin
          // the array drops the fill itself if a flush lands on this edge
          if (i_ptw_resp_valid) begin
            r_state <= ST_READY;
          end else if (i_sfence_valid) begin
            r_state <= ST_WAIT_INVALIDATE;
          end
        end
        default: begin
          if (i_ptw_resp_valid) begin
            r_state <= ST_READY;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_req_ready & i_req_valid & o_resp_miss) begin
      r_refill_vpn <= w_vpn;
    end
  end

endmodule

// File: ptw/ptw.sv
`timescale 1ns/1ps

module ptw
  import sv32_pkg::*, mmu_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  input  logic [VADDR_W-1:0]   i_satp,

  input  logic                 i_req_valid,
  input  logic [VPN_W-1:0]     i_req_vpn,
  output logic                 o_req_ready,
  output logic                 o_resp_valid,
  output logic [PTE_WIDTH-1:0] o_resp_pte,
  output logic                 o_resp_mega,

  // Wishbone classic read master
  output logic                 o_wb_cyc,
  output logic                 o_wb_stb,
  output logic [PADDR_W-1:0]   o_wb_adr,
  input  logic [PTE_WIDTH-1:0] i_wb_dat,
  input  logic                 i_wb_ack
);

  ptw_state_t r_state;
  logic                 r_cyc;
  logic [VPN_W-1:0]     r_vpn;
  logic [PADDR_W-1:0]   r_adr;
  logic [PTE_WIDTH-1:0] r_pte;
  logic                 r_mega;

  logic                 w_ack;
  logic                 w_leaf;
  logic                 w_wr_bad;
  logic                 w_pointer;
  logic                 w_fault;
  logic [PTE_WIDTH-1:0] w_res_pte;

  assign w_ack = r_cyc & i_wb_ack;

  // ------------------------------------------------------------------------
  // decode of the returned entry
  // ------------------------------------------------------------------------

  assign w_leaf    = i_wb_dat[PTE_R] | i_wb_dat[PTE_X];
  assign w_wr_bad  = i_wb_dat[PTE_W] & ~i_wb_dat[PTE_R];
  assign w_pointer = i_wb_dat[PTE_V] & ~w_leaf & ~i_wb_dat[PTE_W];

  always_comb begin
    if (r_state == PTW_L1) begin
      // a megapage leaf needs PPN[0] clear
      w_fault = ~i_wb_dat[PTE_V] | w_wr_bad
              | (w_leaf & (|i_wb_dat[PTE_PPN_LSB +: VPN_PART_W]));
    end else begin
      // level 0 has to end in a leaf
      w_fault = ~i_wb_dat[PTE_V] | w_wr_bad | ~w_leaf;
    end
    w_res_pte        = i_wb_dat;
    w_res_pte[PTE_V] = i_wb_dat[PTE_V] & ~w_fault;
  end

  // ------------------------------------------------------------------------
  // walk control
  // ------------------------------------------------------------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= PTW_IDLE;
      r_cyc   <= 1'b0;
    end else begin
      case (r_state)
        PTW_IDLE: begin
          if (i_req_valid) begin
            r_state <= PTW_L1;
            r_cyc   <= 1'b1;
          end
        end
        PTW_L1: begin
          if (w_ack) begin
            r_cyc   <= 1'b0;
            r_state <= w_pointer ? PTW_L0 : PTW_DONE;
          end
        end
        PTW_L0: begin
          // bus is idle for one cycle between the two reads
          if (!r_cyc) begin
            r_cyc <= 1'b1;
          end else if (w_ack) begin
            r_cyc   <= 1'b0;
            r_state <= PTW_DONE;
          end
        end
        default: begin
          r_state <= PTW_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((r_state == PTW_IDLE) & i_req_valid) begin
      r_vpn <= i_req_vpn;
      r_adr <= {i_satp[PPN_W-1:0], i_req_vpn[VPN_W-1 -: VPN_PART_W], 2'b00};
    end else if (w_ack) begin
      // next level address, only used when the entry was a pointer
      r_adr  <= {i_wb_dat[PTE_WIDTH-1:PTE_PPN_LSB], r_vpn[VPN_PART_W-1:0], 2'b00};
      r_pte  <= w_res_pte;
      r_mega <= (r_state == PTW_L1);
    end
  end

  assign o_req_ready  = (r_state == PTW_IDLE);
  assign o_resp_valid = (r_state == PTW_DONE);
  assign o_resp_pte   = r_pte;
  assign o_resp_mega  = r_mega;

  assign o_wb_cyc = r_cyc;
  assign o_wb_stb = r_cyc;
  assign o_wb_adr = r_adr;

endmodule

// File: rtl/mmu_top.sv
`timescale 1ns/1ps

module mmu_top
  import sv32_pkg::*, mmu_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  input  logic                 i_req_valid,
  input  logic [VADDR_W-1:0]   i_req_vaddr,
  input  acc_cmd_t             i_req_cmd,
  input  logic [1:0]           i_req_size,
  output logic                 o_req_ready,
  output logic                 o_resp_miss,
  output logic [PADDR_W-1:0]   o_resp_paddr,
  output logic                 o_resp_pf,
  output logic                 o_resp_ma,

  input  logic                 i_sfence_valid,
  input  logic                 i_kill,
  input  priv_t                i_priv,
  input  logic [VADDR_W-1:0]   i_satp,
  input  logic                 i_mstatus_sum,
  input  logic                 i_mstatus_mxr,

  output logic                 o_wb_cyc,
  output logic                 o_wb_stb,
  output logic [PADDR_W-1:0]   o_wb_adr,
  input  logic [PTE_WIDTH-1:0] i_wb_dat,
  input  logic                 i_wb_ack
);

  // TLB to walker
  logic                 ptw_req_valid;
  logic [VPN_W-1:0]     ptw_req_vpn;
  logic                 ptw_req_ready;
  logic                 ptw_resp_valid;
  logic [PTE_WIDTH-1:0] ptw_resp_pte;
  logic                 ptw_resp_mega;

  tlb tlb_i (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_req_valid      (i_req_valid),
    .i_req_vaddr      (i_req_vaddr),
    .i_req_cmd        (i_req_cmd),
    .i_req_size       (i_req_size),
    .o_req_ready      (o_req_ready),
    .o_resp_miss      (o_resp_miss),
    .o_resp_paddr     (o_resp_paddr),
    .o_resp_pf        (o_resp_pf),
    .o_resp_ma        (o_resp_ma),
    .i_sfence_valid   (i_sfence_valid),
    .i_kill           (i_kill),
    .i_priv           (i_priv),
    .i_satp_mode      (i_satp[SATP_MODE_BIT]),
    .i_mstatus_sum    (i_mstatus_sum),
    .i_mstatus_mxr    (i_mstatus_mxr),
    .o_ptw_req_valid  (ptw_req_valid),
    .o_ptw_req_vpn    (ptw_req_vpn),
    .i_ptw_req_ready  (ptw_req_ready),
    .i_ptw_resp_valid (ptw_resp_valid),
    .i_ptw_resp_pte   (ptw_resp_pte),
    .i_ptw_resp_mega  (ptw_resp_mega)
  );

  ptw ptw_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_satp       (i_satp),
    .i_req_valid  (ptw_req_valid),
    .i_req_vpn    (ptw_req_vpn),
    .o_req_ready  (ptw_req_ready),
    .o_resp_valid (ptw_resp_valid),
    .o_resp_pte   (ptw_resp_pte),
    .o_resp_mega  (ptw_resp_mega),
    .o_wb_cyc     (o_wb_cyc),
    .o_wb_stb     (o_wb_stb),
    .o_wb_adr     (o_wb_adr),
    .i_wb_dat     (i_wb_dat),
    .i_wb_ack     (i_wb_ack)
  );

endmodule

// File: test/mmu_checker.sv
`timescale 1ns/1ps

module mmu_checker
  import sv32_pkg::*, mmu_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_req_valid,
  input  logic [VADDR_W-1:0]   i_req_vaddr,
  input  acc_cmd_t             i_req_cmd,
  input  logic [1:0]           i_req_size,
  input  logic                 i_req_ready,
  input  logic                 i_resp_miss,
  input  logic [PADDR_W-1:0]   i_resp_paddr,
  input  logic                 i_resp_pf,
  input  logic                 i_resp_ma,
  input  logic                 i_sfence_valid,
  input  logic                 i_kill,
  input  priv_t                i_priv,
  input  logic [VADDR_W-1:0]   i_satp,
  input  logic                 i_mstatus_sum,
  input  logic                 i_mstatus_mxr,
  input  logic                 i_wb_cyc,
  input  logic                 i_wb_stb,
  input  logic [PTE_WIDTH-1:0] i_mem [4096],
  output int                   o_error_count
);

  logic in_request;
  logic expect_ready;

  // reference view of what the TLB holds
  logic [TLB_ENTRIES-1:0] model_valid;
  logic [VPN_W-1:0]       model_tag [TLB_ENTRIES];
  logic                   model_mega [TLB_ENTRIES];
  logic [TLB_IDX_W-1:0]   model_victim;

  // walk whose result is still owed to the TLB
  logic                   fill_pending;
  logic [VPN_W-1:0]       fill_vpn;
  logic                   fill_mega;

  function automatic logic [31:0] read_pte(logic [PADDR_W-1:0] pa);
    return i_mem[pa[13:2]];
  endfunction

  // ------------------------------------------------------------------------
  // reference walk and permission rules
  // ------------------------------------------------------------------------

  task automatic walk_model(input logic [31:0] va, output logic fault,
                            output logic [31:0] leaf, output logic mega);
    logic [31:0] pte;
    pte   = read_pte({i_satp[21:0], va[31:22], 2'b00});
    mega  = 1'b1;
    fault = 1'b0;
    if (!pte[PTE_V] || (pte[PTE_W] && !pte[PTE_R])) begin
      fault = 1'b1;
    end else if (pte[PTE_R] || pte[PTE_X]) begin
      fault = (pte[19:10] != 10'd0);
    end else begin
      mega = 1'b0;
      pte  = read_pte({pte[31:10], va[21:12], 2'b00});
      fault = !pte[PTE_V] || (pte[PTE_W] && !pte[PTE_R]) || !(pte[PTE_R] || pte[PTE_X]);
    end
    leaf = pte;
  endtask

  function automatic logic access_denied(logic [31:0] pte);
    logic deny;
    case (i_req_cmd)
      CMD_STORE: deny = !pte[PTE_W] || !pte[PTE_D];
      CMD_LOAD:  deny = !(pte[PTE_R] || (pte[PTE_X] && i_mstatus_mxr));
      default:   deny = !pte[PTE_X];
    endcase
    if (!pte[PTE_A]) deny = 1'b1;
    if (i_priv == PRV_U && !pte[PTE_U]) deny = 1'b1;
    if (i_priv == PRV_S && pte[PTE_U] && (i_req_cmd == CMD_FETCH || !i_mstatus_sum)) begin
      deny = 1'b1;
    end
    return deny;
  endfunction

  // megapage entries cover every VPN[0]
  function automatic logic tlb_holds(logic [VPN_W-1:0] vpn);
    logic found;
    found = 1'b0;
    for (int e = 0; e < TLB_ENTRIES; e++) begin
      if (model_valid[e] && (model_tag[e][19:10] == vpn[19:10])
          && (model_mega[e] || (model_tag[e][9:0] == vpn[9:0]))) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  task automatic report_value(string name, logic [PADDR_W-1:0] exp, logic [PADDR_W-1:0] got);
    $display("Error at %0t: %s expected %h, got %h", $time, name, exp, got);
    o_error_count++;
  endtask

  task automatic report_event(string msg);
    $display("Error at %0t: %s", $time, msg);
    o_error_count++;
  endtask

  // outputs are settled by the falling edge
  always @(negedge i_clk) begin : compare
    logic vm_on, acc, fault, mega, exp_pf, exp_ma, exp_miss;
    logic [31:0] leaf;
    logic [PADDR_W-1:0] exp_pa;
    if (!i_reset_n) begin
      in_request    = 1'b0;
      expect_ready  = 1'b0;
      model_valid   = '0;
      model_victim  = '0;
      fill_pending  = 1'b0;
      o_error_count = 0;
    end else begin
      vm_on = i_satp[SATP_MODE_BIT] && (i_priv != PRV_M);
      acc   = i_req_valid && i_req_ready;
      if (i_wb_stb !== i_wb_cyc) begin
        report_event("o_wb_stb does not follow o_wb_cyc");
      end
      // the refill was written on the edge before ready came back
      if (fill_pending && i_req_ready) begin
        model_valid[model_victim] = 1'b1;
        model_tag[model_victim]   = fill_vpn;
        model_mega[model_victim]  = fill_mega;
        model_victim              = model_victim + 1'b1;
        fill_pending              = 1'b0;
      end
      if (expect_ready && !i_req_ready) begin
        report_event("o_req_ready stayed low after a kill of the pending walk");
      end
      expect_ready = 1'b0;
      if (acc) begin
        case (i_req_size)
          2'd0:    exp_ma = 1'b0;
          2'd1:    exp_ma = i_req_vaddr[0];
          default: exp_ma = |i_req_vaddr[1:0];
        endcase
        if (i_resp_ma !== exp_ma) report_value("o_resp_ma", 34'(exp_ma), 34'(i_resp_ma));
        if (!vm_on) begin
          if (i_resp_miss) report_value("o_resp_miss", 34'd0, 34'd1);
          if (i_resp_pf) report_value("o_resp_pf", 34'd0, 34'd1);
          if (i_resp_paddr !== {2'b00, i_req_vaddr}) begin
            report_value("o_resp_paddr", {2'b00, i_req_vaddr}, i_resp_paddr);
          end
        end else begin
          exp_miss = !tlb_holds(i_req_vaddr[31:12]);
          if (i_resp_miss !== exp_miss) begin
            report_value("o_resp_miss", 34'(exp_miss), 34'(i_resp_miss));
          end
          if (!i_resp_miss) begin
            walk_model(i_req_vaddr, fault, leaf, mega);
            exp_pf = fault || access_denied(leaf);
            if (i_resp_pf !== exp_pf) report_value("o_resp_pf", 34'(exp_pf), 34'(i_resp_pf));
            if (!exp_pf) begin
              exp_pa = mega ? {leaf[31:20], i_req_vaddr[21:0]}
                            : {leaf[31:10], i_req_vaddr[11:0]};
              if (i_resp_paddr !== exp_pa) report_value("o_resp_paddr", exp_pa, i_resp_paddr);
            end
          end
        end
      end
      // the cycle after an accepted miss is the request state
      if (in_request && i_kill) begin
        expect_ready = 1'b1;
        fill_pending = 1'b0;
      end
      // a flush empties the TLB and the walk in flight is never written
      if (i_sfence_valid) begin
        model_valid  = '0;
        fill_pending = 1'b0;
      end
      in_request = acc && vm_on && i_resp_miss;
      if (in_request) begin
        walk_model(i_req_vaddr, fault, leaf, mega);
        fill_pending = 1'b1;
        fill_vpn     = i_req_vaddr[31:12];
        fill_mega    = mega;
      end
    end
  end

endmodule

// File: test/tb_mmu.sv
`timescale 1ns/1ps

module tb_mmu
  import sv32_pkg::*, mmu_pkg::*;
;

  localparam int NUM_REQ   = 400;
  localparam int MEM_WORDS = 4096;

  logic                 clk;
  logic                 reset_n;
  logic                 req_valid;
  logic [VADDR_W-1:0]   req_vaddr;
  acc_cmd_t             req_cmd;
  logic [1:0]           req_size;
  logic                 req_ready;
  logic                 resp_miss;
  logic [PADDR_W-1:0]   resp_paddr;
  logic                 resp_pf;
  logic                 resp_ma;
  logic                 sfence_valid;
  logic                 kill;
  priv_t                priv;
  logic [VADDR_W-1:0]   satp;
  logic                 sum;
  logic                 mxr;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic [PADDR_W-1:0]   wb_adr;
  logic [PTE_WIDTH-1:0] wb_dat;
  logic                 wb_ack;

  logic [PTE_WIDTH-1:0] mem [MEM_WORDS];
  logic [VPN_W-1:0]     vpn_pool [16];
  integer               seed;
  int                   error_count;
  int                   done_count;
  int                   wait_cnt;
  logic                 seen_ready;
  logic                 seen_miss;
  logic [31:0]          r;

  mmu_top mmu_top_i (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_req_valid    (req_valid),
    .i_req_vaddr    (req_vaddr),
    .i_req_cmd      (req_cmd),
    .i_req_size     (req_size),
    .o_req_ready    (req_ready),
    .o_resp_miss    (resp_miss),
    .o_resp_paddr   (resp_paddr),
    .o_resp_pf      (resp_pf),
    .o_resp_ma      (resp_ma),
    .i_sfence_valid (sfence_valid),
    .i_kill         (kill),
    .i_priv         (priv),
    .i_satp         (satp),
    .i_mstatus_sum  (sum),
    .i_mstatus_mxr  (mxr),
    .o_wb_cyc       (wb_cyc),
    .o_wb_stb       (wb_stb),
    .o_wb_adr       (wb_adr),
    .i_wb_dat       (wb_dat),
    .i_wb_ack       (wb_ack)
  );

  mmu_checker mmu_checker_i (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_req_valid    (req_valid),
    .i_req_vaddr    (req_vaddr),
    .i_req_cmd      (req_cmd),
    .i_req_size     (req_size),
    .i_req_ready    (req_ready),
    .i_resp_miss    (resp_miss),
    .i_resp_paddr   (resp_paddr),
    .i_resp_pf      (resp_pf),
    .i_resp_ma      (resp_ma),
    .i_sfence_valid (sfence_valid),
    .i_kill         (kill),
    .i_priv         (priv),
    .i_satp         (satp),
    .i_mstatus_sum  (sum),
    .i_mstatus_mxr  (mxr),
    .i_wb_cyc       (wb_cyc),
    .i_wb_stb       (wb_stb),
    .i_mem          (mem),
    .o_error_count  (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // page tables: root at page 0, level-0 tables at pages 1 and 2
  // ------------------------------------------------------------------------

  task automatic build_page_tables();
    logic [31:0] rnd;
    logic [7:0]  flags;
    for (int a = 0; a < MEM_WORDS; a++) begin
      rnd = $random(seed);
      mem[a] = rnd ^ {a[15:0], a[15:0]};
    end
    for (int i = 0; i < 1024; i++) begin
      rnd = $random(seed);
      flags = rnd[7:0] | 8'h01;
      if (!(flags[PTE_R] | flags[PTE_X])) begin
        flags[PTE_R] = 1'b1;
      end
      case (rnd[31:29])
        3'd0, 3'd1, 3'd2, 3'd3: mem[i] = {20'd0, rnd[8] ? 2'd2 : 2'd1, 2'b00, 8'h01};
        3'd4, 3'd5:             mem[i] = {rnd[27:16], 10'd0, 2'b00, flags};
        // megapage whose low ppn field is not zero
        3'd6:                   mem[i] = {rnd[27:16], 9'd0, 1'b1, 2'b00, flags};
        default:                mem[i] = mem[i];
      endcase
    end
    for (int a = 1024; a < 3072; a++) begin
      rnd = $random(seed);
      flags = rnd[7:0];
      if (rnd[9:8] != 2'd0) begin
        flags[PTE_V] = 1'b1;
      end
      mem[a] = {rnd[31:10], 2'b00, flags};
    end
    // small vpn pool so that hits recur, larger than the TLB
    for (int p = 0; p < 16; p++) begin
      rnd = $random(seed);
      vpn_pool[p] = {7'd0, rnd[12:10], rnd[29:20]};
    end
  endtask

  task automatic new_request();
    r = $random(seed);
    req_vaddr = {vpn_pool[r[3:0]], r[15:4]};
    req_cmd   = (r[17:16] == 2'd3) ? CMD_LOAD : acc_cmd_t'(r[17:16]);
    req_size  = (r[19:18] == 2'd3) ? 2'd2 : r[19:18];
    priv      = (r[22:20] == 3'd7) ? PRV_M : (r[20] ? PRV_S : PRV_U);
    sum       = r[23];
    mxr       = r[24];
    satp      = {(r[27:25] != 3'd0), 31'd0};
  endtask

  // Wishbone slave with 0 to 3 wait states
  task automatic serve_wishbone();
    if (wb_ack) begin
      wb_ack = 1'b0;
      r = $random(seed);
      wait_cnt = int'(r[1:0]);
    end else if (wb_cyc & wb_stb) begin
      if (wait_cnt == 0) begin
        wb_ack = 1'b1;
        wb_dat = mem[wb_adr[13:2]];
      end else begin
        wait_cnt--;
      end
    end
  endtask

  initial begin
    seed         = 71;
    reset_n      = 1'b0;
    req_valid    = 1'b0;
    req_vaddr    = '0;
    req_cmd      = CMD_LOAD;
    req_size     = 2'd0;
    sfence_valid = 1'b0;
    kill         = 1'b0;
    priv         = PRV_S;
    satp         = '0;
    sum          = 1'b0;
    mxr          = 1'b0;
    wb_dat       = '0;
    wb_ack       = 1'b0;
    wait_cnt     = 0;
    done_count   = 0;
    seen_ready   = 1'b0;
    seen_miss    = 1'b0;
    build_page_tables();
    new_request();
    repeat (3) @(posedge clk);
    #1 reset_n = 1'b1;
    while (done_count < NUM_REQ) begin
      @(posedge clk);
      #1;
      serve_wishbone();
      // a miss keeps the same access for the retry
      if (req_valid & seen_ready & !seen_miss) begin
        done_count++;
        new_request();
      end
      r = $random(seed);
      kill         = (r[2:0] == 3'd0);
      sfence_valid = 1'b0;
      req_valid    = 1'b1;
      if (r[8:4] == 5'd0) begin
        sfence_valid = 1'b1;
        if (req_ready) begin
          req_valid = 1'b0;
        end
      end
      #2;
      seen_ready = req_ready;
      seen_miss  = resp_miss;
    end
    repeat (2) @(posedge clk);
    $display("checked %0d requests, error count %0d", done_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(NUM_REQ * 40 * 8);
    $display("Timeout: requests stopped completing, the MMU seems to hang");
    $display("Errors found");
    $finish;
  end

endmodule

// File: vlog.f
common/sv32_pkg.sv
common/mmu_pkg.sv
tlb/tlb_entry_array.sv
tlb/tlb.sv
ptw/ptw.sv
rtl/mmu_top.sv
test/mmu_checker.sv
test/tb_mmu.sv

// File: run_sim.sh
#!/bin/sh
# build and run the MMU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_mmu -o sim_mmu
./obj_dir/sim_mmu | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation passed"
